// ==== hdl/btb_defines.svh ====
/*
 * Sizing macros for the fetch branch target buffer.
 * Included by both packages, the RTL and the testbench.
 * The tag and index together cover PC bits 15 down to 2.
 */

`ifndef BTB_DEFINES_SVH
`define BTB_DEFINES_SVH

// Address width
`define XLEN 32

// Direct-mapped table geometry
`define BTB_IDX_LEN 4
`define BTB_SIZE 16
`define BTB_TAG_LEN 10

// Instructions fetched per cycle
`define FETCH_WIDTH 2

// Fetch PC after reset
`define RESET_PC 32'h0000_1000

`endif

// ==== hdl/btb_pkg.sv ====
/*
 * Types that describe the branch target buffer table.
 * An entry is what one table slot stores, an update is one
 * write request coming back from branch resolution.
 */

`include "btb_defines.svh"

package btb_pkg;

   ///////////////////////////////////////////////////////////////////////
   // Table entry
   ///////////////////////////////////////////////////////////////////////

   // 43 bits
   typedef struct packed {
      logic                    valid;
      logic [`BTB_TAG_LEN-1:0] tag;
      logic [`XLEN-1:0]        target;
   } btb_entry_t;

   ///////////////////////////////////////////////////////////////////////
   // Update request
   ///////////////////////////////////////////////////////////////////////

   // Resolved taken branch and where it went, 65 bits
   typedef struct packed {
      logic             en;
      logic [`XLEN-1:0] pc;
      logic [`XLEN-1:0] target;
   } btb_update_t;

endpackage

// ==== hdl/fetch_pkg.sv ====
/*
 * Types that describe the fetch side of the predictor.
 * Per-slot lookup results, the bundle handed downstream each
 * cycle, and the redirect that execute sends back.
 */

`include "btb_defines.svh"

package fetch_pkg;

   // One slot's lookup result, 65 bits
   typedef struct packed {
      logic [`XLEN-1:0] pc;
      logic             hit;
      logic [`XLEN-1:0] target;
   } slot_pred_t;

   ///////////////////////////////////////////////////////////////////////
   // Fetch output
   ///////////////////////////////////////////////////////////////////////

   typedef struct packed {
      logic                                valid;
      logic [`XLEN-1:0]                    fetch_pc;
      logic [`FETCH_WIDTH-1:0]             hit;
      logic [`FETCH_WIDTH-1:0][`XLEN-1:0]  target;
      logic [`XLEN-1:0]                    next_pc;
   } fetch_bundle_t;

   ///////////////////////////////////////////////////////////////////////
   // Execute redirect
   ///////////////////////////////////////////////////////////////////////

   // Overrides any prediction when en is set
   typedef struct packed {
      logic             en;
      logic [`XLEN-1:0] pc;
   } redirect_t;

endpackage

// ==== hdl/fetch_pc_gen.sv ====
/*
 * Fetch PC register and the sequential slot addresses.
 * A redirect wins over the predicted next PC; with fetch_en low
 * and no redirect the PC holds.
 */

`include "btb_defines.svh"

module fetch_pc_gen (
   input  logic                               clock,
   input  logic                               reset,
   input  logic                               fetch_en,
   input  fetch_pkg::redirect_t               redirect,
   input  logic [`XLEN-1:0]                   next_pc,
   output logic [`XLEN-1:0]                   fetch_pc,
   output logic [`FETCH_WIDTH-1:0][`XLEN-1:0] lookup_pc
);

   logic [`XLEN-1:0] pc_reg;

   ///////////////////////////////////////////////////////////////////////
   // PC register
   ///////////////////////////////////////////////////////////////////////

   always_ff @(posedge clock) begin
      if (reset) begin
         pc_reg <= `RESET_PC;
      end else if (redirect.en) begin
         pc_reg <= redirect.pc;
      end else if (fetch_en) begin
         pc_reg <= next_pc;
      end
   end

   assign fetch_pc = pc_reg;

   ///////////////////////////////////////////////////////////////////////
   // Slot addresses
   ///////////////////////////////////////////////////////////////////////

   // Slot i looks at the i-th word after the fetch PC
   always_comb begin
      for (int i = 0; i < `FETCH_WIDTH; i++) begin
         lookup_pc[i] = pc_reg + `XLEN'(4 * i);
      end
   end

endmodule

// ==== hdl/btb_storage.sv ====
/*
 * Direct-mapped entry array of the branch target buffer.
 * Two write ports; when both aim at the same index port 0 wins.
 * The whole array is exposed so each read port can index it.
 */

`include "btb_defines.svh"

module btb_storage (
   input  logic                                     clock,
   input  logic                                     reset,
   input  btb_pkg::btb_update_t                     update_0,
   input  btb_pkg::btb_update_t                     update_1,
   output btb_pkg::btb_entry_t [`BTB_SIZE-1:0]      entries
);

   localparam int IDX_LSB = 2;
   localparam int TAG_LSB = IDX_LSB + `BTB_IDX_LEN;

   btb_pkg::btb_entry_t [`BTB_SIZE-1:0] table_q;

   logic [`BTB_IDX_LEN-1:0] idx_0;
   logic [`BTB_IDX_LEN-1:0] idx_1;
   logic [`BTB_TAG_LEN-1:0] tag_0;
   logic [`BTB_TAG_LEN-1:0] tag_1;
   logic                    wr_1;

   ///////////////////////////////////////////////////////////////////////
   // Address split
   ///////////////////////////////////////////////////////////////////////

   assign idx_0 = update_0.pc[IDX_LSB +: `BTB_IDX_LEN];
   assign tag_0 = update_0.pc[TAG_LSB +: `BTB_TAG_LEN];
   assign idx_1 = update_1.pc[IDX_LSB +: `BTB_IDX_LEN];
   assign tag_1 = update_1.pc[TAG_LSB +: `BTB_TAG_LEN];

   // Port 1 steps aside only when port 0 writes the same index
   assign wr_1 = update_1.en && !(update_0.en && (idx_1 == idx_0));

   ///////////////////////////////////////////////////////////////////////
   // Table write
   ///////////////////////////////////////////////////////////////////////

   always_ff @(posedge clock) begin
      if (reset) begin
         table_q <= '0;
      end else begin
         if (update_0.en) begin
            table_q[idx_0].valid  <= 1'b1;
            table_q[idx_0].tag    <= tag_0;
            table_q[idx_0].target <= update_0.target;
         end
         if (wr_1) begin
            table_q[idx_1].valid  <= 1'b1;
            table_q[idx_1].tag    <= tag_1;
            table_q[idx_1].target <= update_1.target;
         end
      end
   end

   assign entries = table_q;

endmodule

// ==== hdl/btb_read_port.sv ====
/*
 * One lookup slot of the branch target buffer.
 * Purely combinational; a miss reports a zero target.
 */

`include "btb_defines.svh"

module btb_read_port (
   input  logic                                lookup_en,
   input  logic [`XLEN-1:0]                    lookup_pc,
   input  btb_pkg::btb_entry_t [`BTB_SIZE-1:0] entries,
   output fetch_pkg::slot_pred_t               pred
);

   localparam int IDX_LSB = 2;
   localparam int TAG_LSB = IDX_LSB + `BTB_IDX_LEN;

   logic [`BTB_IDX_LEN-1:0] idx;
   logic [`BTB_TAG_LEN-1:0] tag;
   btb_pkg::btb_entry_t     entry;
   logic                    hit;

   // Index and tag of the slot address
   assign idx = lookup_pc[IDX_LSB +: `BTB_IDX_LEN];
   assign tag = lookup_pc[TAG_LSB +: `BTB_TAG_LEN];

   assign entry = entries[idx];

   assign hit = lookup_en && entry.valid && (entry.tag == tag);

   ///////////////////////////////////////////////////////////////////////
   // Slot result
   ///////////////////////////////////////////////////////////////////////

   always_comb begin
      pred.pc     = lookup_pc;
      pred.hit    = hit;
      pred.target = hit ? entry.target : '0;
   end

endmodule

// ==== hdl/next_pc_select.sv ====
/*
 * Picks where fetch goes next and packs the fetch bundle.
 * The lowest slot that hits supplies the target; with no hit,
 * fetch falls through past the whole bundle.
 */

`include "btb_defines.svh"

module next_pc_select (
   input  logic                                      fetch_en,
   input  logic [`XLEN-1:0]                          fetch_pc,
   input  fetch_pkg::slot_pred_t [`FETCH_WIDTH-1:0]  pred,
   output logic [`XLEN-1:0]                          next_pc,
   output fetch_pkg::fetch_bundle_t                  bundle
);

   logic [`XLEN-1:0] seq_pc;
   logic [`XLEN-1:0] sel_pc;

   // Sequential fall-through, 4 bytes per slot
   assign seq_pc = fetch_pc + `XLEN'(4 * `FETCH_WIDTH);

   ///////////////////////////////////////////////////////////////////////
   // Priority select
   ///////////////////////////////////////////////////////////////////////

   // Walk from the top slot down so slot 0 has the last word
   always_comb begin
      sel_pc = seq_pc;
      for (int i = `FETCH_WIDTH - 1; i >= 0; i--) begin
         if (pred[i].hit) begin
            sel_pc = pred[i].target;
         end
      end
   end

   assign next_pc = sel_pc;

   ///////////////////////////////////////////////////////////////////////
   // Bundle
   ///////////////////////////////////////////////////////////////////////

   always_comb begin
      bundle.valid    = fetch_en;
      bundle.fetch_pc = fetch_pc;
      bundle.next_pc  = sel_pc;
      // Hit bits go out as looked up, shadowed ones included
      for (int i = 0; i < `FETCH_WIDTH; i++) begin
         bundle.hit[i]    = pred[i].hit;
         bundle.target[i] = pred[i].target;
      end
   end

endmodule

// ==== hdl/fetch_predictor_top.sv ====
/*
 * Branch prediction front end of the two-wide fetch stage.
 * PC generator, BTB storage, one read port per fetch slot and
 * the next-PC selector. Lookup is same-cycle; updates land at
 * the clock edge and are seen from the next cycle on.
 */

`include "btb_defines.svh"

module fetch_predictor_top (
   input  logic                      clock,
   input  logic                      reset,
   input  logic                      fetch_en,
   input  fetch_pkg::redirect_t      redirect,
   input  btb_pkg::btb_update_t      update_0,
   input  btb_pkg::btb_update_t      update_1,
   output fetch_pkg::fetch_bundle_t  bundle
);

   logic [`XLEN-1:0]                           fetch_pc;
   logic [`XLEN-1:0]                           next_pc;
   logic [`FETCH_WIDTH-1:0][`XLEN-1:0]         lookup_pc;
   btb_pkg::btb_entry_t [`BTB_SIZE-1:0]        entries;
   fetch_pkg::slot_pred_t [`FETCH_WIDTH-1:0]   pred;

   ///////////////////////////////////////////////////////////////////////
   // Fetch PC
   ///////////////////////////////////////////////////////////////////////

   fetch_pc_gen u_pc_gen (
      .clock     (clock),
      .reset     (reset),
      .fetch_en  (fetch_en),
      .redirect  (redirect),
      .next_pc   (next_pc),
      .fetch_pc  (fetch_pc),
      .lookup_pc (lookup_pc)
   );

   ///////////////////////////////////////////////////////////////////////
   // Target table
   ///////////////////////////////////////////////////////////////////////

   btb_storage u_storage (
      .clock    (clock),
      .reset    (reset),
      .update_0 (update_0),
      .update_1 (update_1),
      .entries  (entries)
   );

   // One lookup slice per fetch slot
   generate
      for (genvar i = 0; i < `FETCH_WIDTH; i++) begin : g_slot
         btb_read_port u_read_port (
            .lookup_en (fetch_en),
            .lookup_pc (lookup_pc[i]),
            .entries   (entries),
            .pred      (pred[i])
         );
      end
   endgenerate

   ///////////////////////////////////////////////////////////////////////
   // Next PC
   ///////////////////////////////////////////////////////////////////////

   next_pc_select u_select (
      .fetch_en (fetch_en),
      .fetch_pc (fetch_pc),
      .pred     (pred),
      .next_pc  (next_pc),
      .bundle   (bundle)
   );

endmodule

// ==== verif/fetch_predictor_tb.sv ====
/*
 * Testbench for the two-wide fetch branch prediction front end.
 * A directed table runs first, then a seeded random phase. Every
 * cycle the fetch bundle is compared with a reference model of the
 * BTB and the fetch PC.
 */

`include "btb_defines.svh"

module fetch_predictor_tb;

   localparam int NUM_ROWS     = 15;
   localparam int NUM_RANDOM   = 200;
   localparam int RESET_CYCLES = 3;
   localparam int CYCLE_LIMIT  = NUM_ROWS + NUM_RANDOM + 50;

   // One directed cycle with its expected prediction
   typedef struct packed {
      logic                 fetch_en;
      logic [1:0]           exp_hit;
      logic [`XLEN-1:0]     exp_next;
      fetch_pkg::redirect_t redirect;
      btb_pkg::btb_update_t update_0;
      btb_pkg::btb_update_t update_1;
   } row_t;

   logic                     clock;
   logic                     reset;
   logic                     fetch_en;
   fetch_pkg::redirect_t     redirect;
   btb_pkg::btb_update_t     update_0;
   btb_pkg::btb_update_t     update_1;
   fetch_pkg::fetch_bundle_t bundle;

   row_t table_rows [NUM_ROWS];

   // Reference model of the table and the fetch PC
   logic                    m_valid  [`BTB_SIZE];
   logic [`BTB_TAG_LEN-1:0] m_tag    [`BTB_SIZE];
   logic [`XLEN-1:0]        m_target [`BTB_SIZE];
   logic [`XLEN-1:0]        m_pc;

   logic [31:0] rng_state;
   int          cycle_count;

   fetch_predictor_top UUT (
      .clock    (clock),
      .reset    (reset),
      .fetch_en (fetch_en),
      .redirect (redirect),
      .update_0 (update_0),
      .update_1 (update_1),
      .bundle   (bundle)
   );

   always #4 clock = ~clock;

   always @(posedge clock) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT) begin
         $display("timeout: the run went past %0d cycles without finishing", CYCLE_LIMIT);
         $display("TEST FAILED");
         $fatal(1, "cycle limit reached");
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////////////////////////

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [31:0] next_random();
      rng_state = xorshift(rng_state);
      return rng_state;
   endfunction

   // Word aligned, inside 64 KiB; half of them share four tags near 0x1000
   function automatic logic [`XLEN-1:0] random_pc();
      logic [31:0]      r;
      logic [`XLEN-1:0] pc;
      r = next_random();
      if (r[20]) begin
         pc = {16'h0, 10'h040 + {8'h0, r[9:8]}, r[5:2], 2'b00};
      end else begin
         pc = {16'h0, r[15:2], 2'b00};
      end
      return pc;
   endfunction

   function automatic logic [`BTB_IDX_LEN-1:0] index_of(input logic [`XLEN-1:0] pc);
      return pc[2 +: `BTB_IDX_LEN];
   endfunction

   function automatic logic [`BTB_TAG_LEN-1:0] tag_of(input logic [`XLEN-1:0] pc);
      return pc[2 + `BTB_IDX_LEN +: `BTB_TAG_LEN];
   endfunction

   function automatic row_t make_row(
      input logic             fe,
      input logic [1:0]       hit,
      input logic [`XLEN-1:0] next_pc,
      input logic             rd_en,
      input logic [`XLEN-1:0] rd_pc,
      input logic             u0_en,
      input logic [`XLEN-1:0] u0_pc,
      input logic [`XLEN-1:0] u0_target,
      input logic             u1_en,
      input logic [`XLEN-1:0] u1_pc,
      input logic [`XLEN-1:0] u1_target
   );
      row_t row;
      row.fetch_en        = fe;
      row.exp_hit         = hit;
      row.exp_next        = next_pc;
      row.redirect.en     = rd_en;
      row.redirect.pc     = rd_pc;
      row.update_0.en     = u0_en;
      row.update_0.pc     = u0_pc;
      row.update_0.target = u0_target;
      row.update_1.en     = u1_en;
      row.update_1.pc     = u1_pc;
      row.update_1.target = u1_target;
      return row;
   endfunction

   task automatic compare(input logic [31:0] got, input logic [31:0] expected,
                          input string what);
      if (got !== expected) begin
         $display("mismatch at time %0t: %s is %h, expected %h", $time, what, got, expected);
         $display("TEST FAILED");
         $fatal(1, "bundle check failed");
      end
   endtask

   task automatic drive(input logic en, input fetch_pkg::redirect_t rd,
                        input btb_pkg::btb_update_t u0, input btb_pkg::btb_update_t u1);
      @(posedge clock);
      fetch_en <= en;
      redirect <= rd;
      update_0 <= u0;
      update_1 <= u1;
   endtask

   //////////////////////////////////////////////////////////////////////
   // Reference model
   //////////////////////////////////////////////////////////////////////

   task automatic model_slot(input logic [`XLEN-1:0] pc, output logic hit,
                             output logic [`XLEN-1:0] target);
      logic [`BTB_IDX_LEN-1:0] idx;
      idx    = index_of(pc);
      hit    = fetch_en && m_valid[idx] && (m_tag[idx] == tag_of(pc));
      target = hit ? m_target[idx] : '0;
   endtask

   // Compares every bundle field and returns the predicted next PC
   task automatic check_bundle(output logic [`XLEN-1:0] exp_next);
      logic             hit_0;
      logic             hit_1;
      logic [`XLEN-1:0] target_0;
      logic [`XLEN-1:0] target_1;
      model_slot(m_pc, hit_0, target_0);
      model_slot(m_pc + 32'd4, hit_1, target_1);
      if (hit_0) begin
         exp_next = target_0;
      end else if (hit_1) begin
         exp_next = target_1;
      end else begin
         exp_next = m_pc + 32'd8;
      end
      compare({31'b0, bundle.valid}, {31'b0, fetch_en}, "valid");
      compare(bundle.fetch_pc, m_pc, "fetch_pc");
      compare({30'b0, bundle.hit}, {30'b0, hit_1, hit_0}, "hit");
      compare(bundle.target[0], target_0, "target[0]");
      compare(bundle.target[1], target_1, "target[1]");
      compare(bundle.next_pc, exp_next, "next_pc");
   endtask

   // What the next rising edge does with the inputs now driven
   task automatic advance_model(input logic [`XLEN-1:0] predicted);
      logic [`BTB_IDX_LEN-1:0] idx_0;
      logic [`BTB_IDX_LEN-1:0] idx_1;
      idx_0 = index_of(update_0.pc);
      idx_1 = index_of(update_1.pc);
      if (update_0.en) begin
         m_valid[idx_0]  = 1'b1;
         m_tag[idx_0]    = tag_of(update_0.pc);
         m_target[idx_0] = update_0.target;
      end
      // Update 1 is dropped only behind an update 0 to the same index
      if (update_1.en && !(update_0.en && (idx_1 == idx_0))) begin
         m_valid[idx_1]  = 1'b1;
         m_tag[idx_1]    = tag_of(update_1.pc);
         m_target[idx_1] = update_1.target;
      end
      if (redirect.en) begin
         m_pc = redirect.pc;
      end else if (fetch_en) begin
         m_pc = predicted;
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Directed table
   //////////////////////////////////////////////////////////////////////

   // Columns: fetch_en, hit, next PC, redirect en/pc,
   // then update 0 en/pc/target and update 1 en/pc/target
   task automatic load_table();
      table_rows[0]  = make_row(1'b1, 2'b00, 32'h1008, 1'b0, 32'h0,
                                1'b0, 32'h0, 32'h0, 1'b0, 32'h0, 32'h0);
      table_rows[1]  = make_row(1'b1, 2'b00, 32'h1010, 1'b0, 32'h0,
                                1'b1, 32'h1010, 32'h2000, 1'b0, 32'h0, 32'h0);
      // Both ports at different indices
      table_rows[2]  = make_row(1'b1, 2'b01, 32'h2000, 1'b0, 32'h0,
                                1'b1, 32'h2004, 32'h3000, 1'b1, 32'h2000, 32'h4000);
      table_rows[3]  = make_row(1'b1, 2'b11, 32'h4000, 1'b0, 32'h0,
                                1'b0, 32'h0, 32'h0, 1'b0, 32'h0, 32'h0);
      // Same index, other tag, then overwrite
      table_rows[4]  = make_row(1'b1, 2'b00, 32'h4008, 1'b0, 32'h0,
                                1'b1, 32'h4000, 32'h5000, 1'b0, 32'h0, 32'h0);
      table_rows[5]  = make_row(1'b1, 2'b00, 32'h4010, 1'b1, 32'h4000,
                                1'b1, 32'h1020, 32'h6000, 1'b1, 32'h1060, 32'h7000);
      table_rows[6]  = make_row(1'b1, 2'b01, 32'h5000, 1'b1, 32'h1060,
                                1'b0, 32'h0, 32'h0, 1'b0, 32'h0, 32'h0);
      table_rows[7]  = make_row(1'b1, 2'b00, 32'h1068, 1'b1, 32'h101c,
                                1'b0, 32'h0, 32'h0, 1'b0, 32'h0, 32'h0);
      table_rows[8]  = make_row(1'b1, 2'b10, 32'h6000, 1'b0, 32'h0,
                                1'b0, 32'h0, 32'h0, 1'b0, 32'h0, 32'h0);
      // Stall holds the PC
      table_rows[9]  = make_row(1'b0, 2'b00, 32'h6008, 1'b0, 32'h0,
                                1'b0, 32'h0, 32'h0, 1'b0, 32'h0, 32'h0);
      table_rows[10] = make_row(1'b0, 2'b00, 32'h6008, 1'b0, 32'h0,
                                1'b0, 32'h0, 32'h0, 1'b0, 32'h0, 32'h0);
      table_rows[11] = make_row(1'b1, 2'b00, 32'h6008, 1'b0, 32'h0,
                                1'b0, 32'h0, 32'h0, 1'b0, 32'h0, 32'h0);
      table_rows[12] = make_row(1'b0, 2'b00, 32'h6010, 1'b1, 32'h1010,
                                1'b0, 32'h0, 32'h0, 1'b0, 32'h0, 32'h0);
      // Lone port 1 write at the index of an idle port 0
      table_rows[13] = make_row(1'b0, 2'b00, 32'h1018, 1'b0, 32'h0,
                                1'b0, 32'h1014, 32'h0, 1'b1, 32'h1014, 32'h7000);
      table_rows[14] = make_row(1'b1, 2'b11, 32'h2000, 1'b0, 32'h0,
                                1'b0, 32'h0, 32'h0, 1'b0, 32'h0, 32'h0);
   endtask

   //////////////////////////////////////////////////////////////////////
   // Sequence
   //////////////////////////////////////////////////////////////////////

   initial begin
      row_t                 row;
      logic [`XLEN-1:0]     exp_next;
      logic [31:0]          r;
      fetch_pkg::redirect_t rd;
      btb_pkg::btb_update_t u0;
      btb_pkg::btb_update_t u1;

      clock       = 1'b0;
      reset       = 1'b1;
      fetch_en    = 1'b0;
      redirect    = '0;
      update_0    = '0;
      update_1    = '0;
      rng_state   = 32'd38714;
      cycle_count = 0;
      load_table();
      for (int i = 0; i < `BTB_SIZE; i++) begin
         m_valid[i]  = 1'b0;
         m_tag[i]    = '0;
         m_target[i] = '0;
      end
      m_pc = `RESET_PC;

      repeat (RESET_CYCLES) @(posedge clock);
      reset <= 1'b0;

      for (int i = 0; i < NUM_ROWS; i++) begin
         row = table_rows[i];
         drive(row.fetch_en, row.redirect, row.update_0, row.update_1);
         @(negedge clock);
         check_bundle(exp_next);
         compare({30'b0, bundle.hit}, {30'b0, row.exp_hit}, "table hit");
         compare(bundle.next_pc, row.exp_next, "table next_pc");
         advance_model(exp_next);
      end

      for (int n = 0; n < NUM_RANDOM; n++) begin
         r         = next_random();
         rd.en     = (r[4:2] == 3'b000);
         rd.pc     = random_pc();
         u0.en     = r[0];
         u0.pc     = random_pc();
         u0.target = random_pc();
         u1.en     = r[1];
         u1.pc     = random_pc();
         u1.target = random_pc();
         // Now and then aim both ports at one index
         if (r[9:8] == 2'b00) begin
            u1.pc[2 +: `BTB_IDX_LEN] = u0.pc[2 +: `BTB_IDX_LEN];
         end
         drive(r[7:5] != 3'b000, rd, u0, u1);
         @(negedge clock);
         check_bundle(exp_next);
         advance_model(exp_next);
      end

      $display("TEST PASSED");
      $finish;
   end

endmodule

// ==== list.f ====
+incdir+hdl
hdl/btb_pkg.sv
hdl/fetch_pkg.sv
hdl/fetch_pc_gen.sv
hdl/btb_storage.sv
hdl/btb_read_port.sv
hdl/next_pc_select.sv
hdl/fetch_predictor_top.sv
verif/fetch_predictor_tb.sv

// ==== Makefile ====
# Verilator build and run of the fetch predictor testbench.
# The run's exit status is the test result.

BUILD_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing -f list.f --top-module fetch_predictor_tb \
		-Mdir $(BUILD_DIR) -o fetch_predictor_sim
	./$(BUILD_DIR)/fetch_predictor_sim

clean:
	rm -rf $(BUILD_DIR)
